//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input logic reset_req, // pulse to run a fresh reset
	output logic clk,
	output logic resetN
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		resetN = 1'b0;
		forever begin
			repeat (3) @(posedge clk);
			@(negedge clk);
			resetN = 1'b1;
			@(posedge reset_req);
			@(negedge clk);
			resetN = 1'b0;
		end
	end

endmodule

//--- dv/tb_game_top.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module tb_game_top;

	localparam int CLK_NS = 4;
	localparam int FRAME_CYCLES = 4;
	localparam int BUS_LIMIT = 20;
	localparam int TEST_FRAMES = 128 + 132 + 208 + 30 + 401; // shots, lives, levels, powerups, trees
	localparam int MARGIN_NS = 5000;

	logic clk;
	logic resetN;
	logic reset_req;
	logic frame_tick;
	logic shoot;
	logic [7:0] random;
	logic [3:0] bird_alive;
	logic hit_pulse;
	logic powerup_hit;
	logic out_of_time;
	logic [3:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	logic [31:0] s_wdata;
	logic [3:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [3:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	logic [31:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	logic [7:0] deploy_shot;
	logic [15:0] deploy_tree;
	logic [3:0] deploy_bird;
	logic [3:0] bird_life;
	logic [2:0] tree_speed;
	logic [1:0] bird_speed;
	logic player_red;
	logic player_active;
	logic [1:0] lives;
	logic [3:0] powerups;
	logic add_time;
	logic [7:0] time_to_add;

	int test_errors = 0;
	int total_errors = 0;
	int checks = 0;
	int tests_run = 0;
	logic [31:0] lcg_state = 32'h3c10_9997;
	logic seen_add; // add_time right after the tick
	logic [7:0] seen_bonus;
	logic add_after; // add_time one cycle later

	tb_clock clkgen (
		.reset_req(reset_req),
		.clk(clk),
		.resetN(resetN)
	);

	game_top UUT (.*);

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// status layout from the register map
	function automatic logic [31:0] status_word(input logic [1:0] lv, input logic act,
			input logic [1:0] level, input logic [3:0] pu);
		return {20'b0, pu, 2'b0, level, 1'b0, act, lv};
	endfunction

	task automatic check(input logic ok, input string what);
		checks++;
		assert (ok === 1'b1) else begin
			test_errors++;
			$display("** Error @ %0t: %s", $time, what);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%-9s %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
			test_errors);
		total_errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic drive_idle();
		frame_tick = 1'b0;
		shoot = 1'b0;
		random = 8'h00;
		bird_alive = '0;
		hit_pulse = 1'b0;
		powerup_hit = 1'b0;
		out_of_time = 1'b0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
	endtask

	task automatic restart();
		drive_idle();
		reset_req = 1'b1;
		@(negedge clk);
		reset_req = 1'b0;
		@(posedge resetN); // released on a falling edge
	endtask

	task automatic frame();
		frame_tick = 1'b1;
		@(negedge clk);
		frame_tick = 1'b0;
		seen_add = add_time;
		seen_bonus = time_to_add;
		@(negedge clk);
		add_after = add_time;
		repeat (FRAME_CYCLES - 2) @(negedge clk);
	endtask

	task automatic hit_frame();
		hit_pulse = 1'b1;
		frame();
		hit_pulse = 1'b0;
	endtask

	// runs frames until a shot or bird slot pulses
	task automatic wait_deploy(input bit birds, input int limit, output int frames,
			output logic [7:0] slots);
		frames = 0;
		slots = '0;
		while (slots == '0 && frames < limit) begin
			frame();
			frames++;
			slots = birds ? 8'(deploy_bird) : deploy_shot;
		end
	endtask

	task automatic check_bonus(input string what);
		check(seen_add === 1'b1 && seen_bonus === 8'h10 && add_after === 1'b0,
			$sformatf("%s: add_time %b bonus %h", what, seen_add, seen_bonus));
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int n;
		n = 0;
		s_awaddr = addr;
		s_wdata = data;
		s_wstrb = strb;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!s_bvalid && n < BUS_LIMIT);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		resp = s_bresp;
		if (!s_bvalid) begin
			test_errors++;
			$display("write to address %h was never answered", addr);
		end else begin
			@(negedge clk); // hold off bready one cycle
			check(s_bvalid === 1'b1 && s_bresp === resp, "write response dropped before bready");
			s_bready = 1'b1;
			@(negedge clk);
			s_bready = 1'b0;
			check(s_bvalid === 1'b0, "write response still valid after bready");
		end
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		n = 0;
		s_araddr = addr;
		s_arvalid = 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!s_rvalid && n < BUS_LIMIT);
		s_arvalid = 1'b0;
		data = s_rdata;
		resp = s_rresp;
		if (!s_rvalid) begin
			test_errors++;
			$display("read from address %h was never answered", addr);
		end else begin
			@(negedge clk);
			check(s_rvalid === 1'b1 && s_rdata === data, "read data not held before rready");
			s_rready = 1'b1;
			@(negedge clk);
			s_rready = 1'b0;
			check(s_rvalid === 1'b0, "read response still valid after rready");
		end
	endtask

	task automatic test_regs();
		logic [31:0] wd;
		logic [31:0] rd;
		logic [1:0] resp;
		restart();
		check(add_time === 1'b1 && time_to_add === 8'h99, "initial time load of 99 missing");
		@(negedge clk);
		check(add_time === 1'b0, "initial time load longer than one cycle");
		check(lives === 2'(`GAME_START_LIVES) && player_active === 1'b1, "reset lives wrong");
		check(deploy_shot === '0 && deploy_tree === '0 && deploy_bird === '0,
			"deploy outputs active after reset");
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(resp === axil_pkg::RESP_OKAY && rd === status_word(2'd3, 1'b1,
			game_pkg::LEVEL_1, 4'h0), $sformatf("status %h after reset", rd));
		wd = rand_word();
		axil_write(`GAME_REG_CTRL, wd, 4'hf, resp);
		check(resp === axil_pkg::RESP_OKAY, "ctrl write not accepted");
		axil_read(`GAME_REG_CTRL, rd, resp);
		check(rd === (wd & 32'h3), $sformatf("ctrl reads %h after writing %h", rd, wd));
		axil_write(`GAME_REG_CTRL, 32'h0, 4'hf, resp);
		axil_write(`GAME_REG_CTRL, 32'h3, 4'he, resp); // byte 0 not strobed
		axil_write(`GAME_REG_STATUS, 32'hffff_ffff, 4'hf, resp);
		check(resp === axil_pkg::RESP_SLVERR, "status write not rejected");
		axil_read(`GAME_REG_CTRL, rd, resp);
		check(rd === 32'h0, $sformatf("ctrl changed to %h by masked or status write", rd));
		axil_read(4'h8, rd, resp);
		check(resp === axil_pkg::RESP_SLVERR, "unmapped read not rejected");
		finish_test("regs");
	endtask

	task automatic test_shots();
		int n;
		logic [7:0] slots;
		logic [1:0] resp;
		restart();
		shoot = 1'b1;
		wait_deploy(1'b0, 4, n, slots);
		check(n == 1 && slots === 8'h01, $sformatf("first shot frame %0d slots %b", n, slots));
		axil_write(`GAME_REG_CTRL, 32'h2, 4'h1, resp); // rapid fire
		wait_deploy(1'b0, `GAME_COOLDOWN_NORMAL + 10, n, slots);
		check(n == `GAME_COOLDOWN_NORMAL + 1 && slots === 8'h02,
			$sformatf("normal cooldown: shot after %0d frames slots %b", n, slots));
		wait_deploy(1'b0, `GAME_COOLDOWN_RAPID + 10, n, slots);
		check(n == `GAME_COOLDOWN_RAPID + 1 && slots === 8'h04,
			$sformatf("rapid cooldown: shot after %0d frames slots %b", n, slots));
		shoot = 1'b0;
		finish_test("shots");
	endtask

	task automatic test_lives();
		int n;
		int red;
		logic [31:0] rd;
		logic [1:0] resp;
		restart();
		hit_frame();
		check(lives === 2'd2 && player_red === 1'b1, "first hit did not take a life");
		red = 1;
		n = 0;
		while (player_red && n < `GAME_RED_FRAMES + 10) begin
			hit_pulse = (n == 10); // lands inside the red window
			frame();
			hit_pulse = 1'b0;
			red += player_red;
			n++;
		end
		check(red == `GAME_RED_FRAMES, $sformatf("player_red lasted %0d frames", red));
		check(lives === 2'd2, "hit inside the red window took a life");
		axil_write(`GAME_REG_CTRL, 32'h1, 4'h1, resp); // god mode
		hit_frame();
		check(lives === 2'd2 && player_red === 1'b0, "hit in god mode took a life");
		axil_write(`GAME_REG_CTRL, 32'h0, 4'h1, resp);
		hit_frame();
		check(lives === 2'd1 && player_red === 1'b1, "second hit did not take a life");
		n = 0;
		while (player_red && n < `GAME_RED_FRAMES + 10) begin
			frame();
			n++;
		end
		hit_frame();
		check(player_active === 1'b0, "third hit did not end the game");
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(rd === status_word(2'd0, 1'b0, game_pkg::LEVEL_1, 4'h0),
			$sformatf("status %h after game over", rd));
		finish_test("lives");
	endtask

	task automatic test_levels();
		int n;
		logic [7:0] birds;
		logic [31:0] rd;
		logic [1:0] resp;
		logic [2:0] prev_tree;
		logic [1:0] prev_bird;
		logic [3:0] prev_life;
		restart();
		frame();
		check(deploy_bird === 4'b0001, $sformatf("level 1 start deployed %b", deploy_bird));
		prev_tree = tree_speed;
		prev_bird = bird_speed;
		prev_life = bird_life;
		bird_alive = 4'b0001;
		frame();
		bird_alive = 4'b0000;
		frame();
		check_bonus("last bird of level 1");
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(rd[5:4] === game_pkg::LEVEL_2, $sformatf("level %0d after first clear", rd[5:4]));
		wait_deploy(1'b1, `GAME_LEVEL_PAUSE + 10, n, birds);
		check(n == `GAME_LEVEL_PAUSE + 1 && birds === 8'h03,
			$sformatf("level 2 birds %b after %0d frames", birds, n));
		check(tree_speed > prev_tree && bird_speed >= prev_bird && bird_life > prev_life,
			$sformatf("level 2 speeds %0d/%0d life %0d not harder", tree_speed, bird_speed,
			bird_life));
		prev_tree = tree_speed;
		prev_bird = bird_speed;
		prev_life = bird_life;
		bird_alive = 4'b0011;
		frame();
		bird_alive = 4'b0001;
		frame();
		check_bonus("first bird of level 2");
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(rd[5:4] === game_pkg::LEVEL_2, "level advanced with a bird still alive");
		bird_alive = 4'b0000;
		frame();
		check_bonus("last bird of level 2");
		wait_deploy(1'b1, `GAME_LEVEL_PAUSE + 10, n, birds);
		check(n == `GAME_LEVEL_PAUSE + 1 && birds === 8'h07,
			$sformatf("level 3 birds %b after %0d frames", birds, n));
		check(tree_speed > prev_tree && bird_speed >= prev_bird && bird_life > prev_life,
			$sformatf("level 3 speeds %0d/%0d life %0d not harder", tree_speed, bird_speed,
			bird_life));
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(rd[5:4] === game_pkg::LEVEL_3, $sformatf("level %0d after second clear", rd[5:4]));
		finish_test("levels");
	endtask

	task automatic test_trees();
		int n;
		restart();
		n = 0;
		while (deploy_tree === '0 && n < `GAME_TREE_WAIT + 1) begin
			frame();
			n++;
		end
		check(n == `GAME_TREE_WAIT && deploy_tree === 16'h0001,
			$sformatf("first tree %b after %0d frames", deploy_tree, n));
		frame();
		check(deploy_tree === '0, "tree pulse longer than one frame");
		finish_test("trees");
	endtask

	task automatic test_powerups();
		int n;
		logic [7:0] slots;
		logic [31:0] r;
		logic [31:0] rd;
		logic [3:0] pu;
		logic [1:0] resp;
		restart();
		r = rand_word();
		random = r[7:0];
		powerup_hit = 1'b1;
		frame();
		powerup_hit = 1'b0;
		pu = 4'b0001 << r[7:6];
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(rd === status_word(2'd3, 1'b1, game_pkg::LEVEL_1, pu),
			$sformatf("status %h after power-up %0d", rd, r[7:6]));
		random = {game_pkg::PU_RAPID, r[5:0]};
		powerup_hit = 1'b1;
		frame();
		powerup_hit = 1'b0;
		pu[game_pkg::PU_RAPID] = 1'b1;
		check(powerups === pu, $sformatf("powerups %b, expected %b", powerups, pu));
		shoot = 1'b1;
		wait_deploy(1'b0, 4, n, slots);
		check(n == 1 && slots === 8'h01, "first shot missing with rapid power-up");
		wait_deploy(1'b0, `GAME_COOLDOWN_RAPID + 10, n, slots);
		check(n == `GAME_COOLDOWN_RAPID + 1 && slots === 8'h02,
			$sformatf("rapid power-up: shot after %0d frames", n));
		shoot = 1'b0;
		out_of_time = 1'b1;
		frame();
		out_of_time = 1'b0;
		check(player_active === 1'b0 && lives === 2'd3, "out_of_time did not end the game");
		axil_read(`GAME_REG_STATUS, rd, resp);
		check(rd === status_word(2'd3, 1'b0, game_pkg::LEVEL_1, pu),
			$sformatf("status %h after out_of_time", rd));
		finish_test("powerups");
	endtask

	initial begin
		reset_req = 1'b0;
		drive_idle();
		@(posedge resetN);
		test_regs();
		test_shots();
		test_lives();
		test_levels();
		test_powerups();
		test_trees();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
		if (total_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// frame budget of all tests plus room for bus traffic and resets
	initial begin
		#(TEST_FRAMES * FRAME_CYCLES * CLK_NS + MARGIN_NS);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+src
src/game_pkg.sv
src/axil_pkg.sv
src/axil_if.sv
src/level_if.sv
src/game_regs.sv
src/level_fsm.sv
src/game_controller.sv
src/game_top.sv
dv/tb_clock.sv
dv/tb_game_top.sv

//--- src/axil_if.sv
`timescale 1ns/1ps

interface axil_if;
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport master (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);
endinterface

//--- src/axil_pkg.sv
`include "game_defs.svh"

package axil_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// word index, taken from address bits 3:2
	typedef enum logic [1:0] {
		REG_CTRL = 2'(`GAME_REG_CTRL >> 2),
		REG_STATUS = 2'(`GAME_REG_STATUS >> 2)
	} reg_index_e;

endpackage

//--- src/game_controller.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module game_controller (
	input logic clk,
	input logic resetN,
	input logic frame_tick, // start of frame
	input logic shoot,
	input logic god_mode,
	input logic rapid_fire,
	input logic [7:0] random,
	input logic [`GAME_MAX_BIRDS-1:0] bird_alive,
	input logic hit_pulse,
	input logic powerup_hit,
	input logic out_of_time,
	level_if.ctrl lvl,
	output logic [`GAME_MAX_SHOTS-1:0] deploy_shot,
	output logic [`GAME_MAX_TREES-1:0] deploy_tree,
	output logic [`GAME_MAX_BIRDS-1:0] deploy_bird,
	output logic [3:0] bird_life,
	output logic [2:0] tree_speed,
	output logic [1:0] bird_speed,
	output logic player_red,
	output logic player_active,
	output logic [1:0] lives,
	output logic [3:0] powerups,
	output logic add_time,
	output logic [7:0] time_to_add // two bcd digits
);

	localparam int SHOT_W = $clog2(`GAME_MAX_SHOTS);
	localparam int TREE_W = $clog2(`GAME_MAX_TREES);
	localparam int COOL_W = $clog2(`GAME_COOLDOWN_NORMAL + 1);
	localparam int WAIT_W = $clog2(`GAME_TREE_WAIT + 1);
	localparam int RED_W = $clog2(`GAME_RED_FRAMES + 1);
	localparam int PAUSE_W = $clog2(`GAME_LEVEL_PAUSE + 1);
	localparam int PU_W = $clog2(`GAME_POWERUP_FRAMES + 1);
	localparam int ALIVE_W = $clog2(`GAME_MAX_BIRDS + 1);
	localparam int PEND_W = 5;

	logic [SHOT_W-1:0] shot_idx;
	logic [TREE_W-1:0] tree_idx;
	logic [COOL_W-1:0] cooldown;
	logic [COOL_W-1:0] cool_load;
	logic [WAIT_W-1:0] tree_cnt;
	logic [PEND_W-1:0] pending_trees;
	logic [PEND_W-1:0] pending_add;
	logic [RED_W-1:0] red_cnt;
	logic [PAUSE_W-1:0] pause_cnt;
	logic [PU_W-1:0] pu_cnt;
	logic [ALIVE_W-1:0] alive_cnt;
	logic [ALIVE_W-1:0] last_alive;
	logic level_done;
	logic start_level;
	logic level_up_r;
	logic invincible;
	logic tree_release;
	game_pkg::powerup_e pu_sel;

	assign alive_cnt = ALIVE_W'($countones(bird_alive));
	assign invincible = (red_cnt != '0) || god_mode || powerups[game_pkg::PU_INVINCIBLE];
	assign cool_load = (rapid_fire || powerups[game_pkg::PU_RAPID]) ?
		COOL_W'(`GAME_COOLDOWN_RAPID) : COOL_W'(`GAME_COOLDOWN_NORMAL);
	assign tree_release = (pending_trees != '0) && (tree_cnt == WAIT_W'(`GAME_TREE_WAIT - 1));
	assign pending_add = start_level ? PEND_W'(lvl.cfg.trees_to_add) : '0;
	assign pu_sel = game_pkg::powerup_e'(random[7:6]);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			deploy_shot <= '0;
			deploy_tree <= '0;
			deploy_bird <= '0;
			bird_life <= '0;
			tree_speed <= '0;
			bird_speed <= '0;
			player_active <= 1'b1;
			lives <= 2'(`GAME_START_LIVES);
			powerups <= '0;
			add_time <= 1'b1; // initial time load
			time_to_add <= `GAME_START_TIME;
			level_up_r <= 1'b0;
			start_level <= 1'b1; // birds go out on the first tick
			level_done <= 1'b1;
			shot_idx <= '0;
			tree_idx <= '0;
			cooldown <= '0;
			tree_cnt <= '0;
			pending_trees <= '0;
			red_cnt <= '0;
			pause_cnt <= '0;
			pu_cnt <= '0;
			last_alive <= '0;
		end else begin
			add_time <= 1'b0;
			time_to_add <= 8'h00;
			level_up_r <= 1'b0;
			if (frame_tick) begin
				deploy_shot <= '0;
				deploy_tree <= '0;
				deploy_bird <= '0;
				start_level <= 1'b0;
				tree_speed <= lvl.cfg.tree_speed;
				bird_speed <= lvl.cfg.bird_speed;
				bird_life <= lvl.cfg.bird_life;
				last_alive <= alive_cnt;
				cooldown <= (cooldown != '0) ? cooldown - 1'b1 : '0;
				red_cnt <= (red_cnt != '0) ? red_cnt - 1'b1 : '0;
				pause_cnt <= (pause_cnt != '0) ? pause_cnt - 1'b1 : '0;
				pu_cnt <= (pu_cnt != '0) ? pu_cnt - 1'b1 : '0;
				tree_cnt <= (tree_cnt == WAIT_W'(`GAME_TREE_WAIT - 1)) ? '0 : tree_cnt + 1'b1;
				pending_trees <= pending_trees - PEND_W'(tree_release) + pending_add;

				if (shoot && cooldown == '0) begin
					deploy_shot[shot_idx] <= 1'b1;
					shot_idx <= shot_idx + 1'b1; // slot count is a power of two
					cooldown <= cool_load;
				end

				if (tree_release) begin
					deploy_tree[tree_idx] <= 1'b1;
					tree_idx <= tree_idx + 1'b1;
				end

				if (start_level) begin
					for (int i = 0; i < `GAME_MAX_BIRDS; i++) begin
						deploy_bird[i] <= (i <= lvl.cfg.bird_count);
					end
				end

				if (hit_pulse && !invincible && player_active) begin
					lives <= lives - 2'd1;
					if (lives == 2'd1) begin
						player_active <= 1'b0; // game over
					end else begin
						red_cnt <= RED_W'(`GAME_RED_FRAMES);
					end
				end

				if (out_of_time) begin
					player_active <= 1'b0;
				end

				// level clear is armed again once birds are seen alive
				if (bird_alive != '0) begin
					level_done <= 1'b0;
				end else if (!level_done) begin
					level_done <= 1'b1;
					level_up_r <= 1'b1;
					pause_cnt <= PAUSE_W'(`GAME_LEVEL_PAUSE);
				end

				if (pause_cnt == PAUSE_W'(1) && bird_alive == '0) begin
					start_level <= 1'b1;
				end

				if (alive_cnt < last_alive) begin
					add_time <= 1'b1;
					time_to_add <= `GAME_KILL_BONUS;
				end

				if (pu_cnt == '0) begin
					powerups <= '0;
				end
				if (powerup_hit) begin
					powerups[pu_sel] <= 1'b1;
					pu_cnt <= PU_W'(`GAME_POWERUP_FRAMES); // restarts for all active
				end
			end
		end
	end

	assign player_red = (red_cnt != '0);
	assign lvl.level_up = level_up_r;

endmodule

//--- src/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// playfield slots
`define GAME_MAX_SHOTS 8
`define GAME_MAX_TREES 16
`define GAME_MAX_BIRDS 4

// frame counts
`define GAME_COOLDOWN_NORMAL 100
`define GAME_COOLDOWN_RAPID 25
`define GAME_TREE_WAIT 400 // one tree released per period
`define GAME_RED_FRAMES 64
`define GAME_LEVEL_PAUSE 100
`define GAME_POWERUP_FRAMES 5000

`define GAME_START_LIVES 3

// bonus time, two bcd digits
`define GAME_START_TIME 8'h99
`define GAME_KILL_BONUS 8'h10

// host register byte addresses
`define GAME_REG_CTRL 4'h0
`define GAME_REG_STATUS 4'h4

`endif

//--- src/game_pkg.sv
package game_pkg;

	typedef enum logic [1:0] {
		LEVEL_1,
		LEVEL_2,
		LEVEL_3,
		LEVEL_4
	} level_state_e;

	// bit position inside the powerups vector
	typedef enum logic [1:0] {
		PU_INVINCIBLE,
		PU_RAPID,
		PU_DAMAGE,
		PU_DOUBLE
	} powerup_e;

	typedef struct packed {
		logic [2:0] tree_speed;
		logic [1:0] bird_speed;
		logic [1:0] bird_count; // birds minus one
		logic [1:0] trees_to_add;
		logic [3:0] bird_life;
	} level_cfg_t;

endpackage

//--- src/game_regs.sv
`timescale 1ns/1ps

module game_regs (
	input logic clk,
	input logic resetN,
	axil_if.slave bus,
	input logic [1:0] lives,
	input logic player_active,
	input game_pkg::level_state_e level,
	input logic [3:0] powerups,
	output logic god_mode,
	output logic rapid_fire
);

	logic [1:0] ctrl_q;
	logic [31:0] status;
	logic [31:0] rd_word;
	logic [31:0] rdata_q;
	logic bvalid_q;
	logic rvalid_q;
	logic wr_go;
	logic rd_go;
	logic wr_ok;
	logic rd_ok;
	axil_pkg::reg_index_e wr_idx;
	axil_pkg::reg_index_e rd_idx;
	axil_pkg::axil_resp_e bresp_q;
	axil_pkg::axil_resp_e rresp_q;

	assign status = {20'b0, powerups, 2'b0, level, 1'b0, player_active, lives};

	// aw and w go in together, held off while b is pending
	assign wr_go = bus.awvalid && bus.wvalid && !bvalid_q;
	assign rd_go = bus.arvalid && !rvalid_q;

	assign bus.awready = wr_go;
	assign bus.wready = wr_go;
	assign bus.arready = !rvalid_q;

	assign wr_idx = axil_pkg::reg_index_e'(bus.awaddr[3:2]);
	assign rd_idx = axil_pkg::reg_index_e'(bus.araddr[3:2]);

	assign wr_ok = (bus.awaddr[1:0] == 2'b00) && (wr_idx == axil_pkg::REG_CTRL); // status is ro

	always_comb begin
		rd_word = '0;
		rd_ok = 1'b0;
		if (bus.araddr[1:0] == 2'b00) begin
			case (rd_idx)
				axil_pkg::REG_CTRL: begin
					rd_word = {30'b0, ctrl_q};
					rd_ok = 1'b1;
				end
				axil_pkg::REG_STATUS: begin
					rd_word = status;
					rd_ok = 1'b1;
				end
				default: rd_ok = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ctrl_q <= 2'b00;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_go) begin
				bvalid_q <= 1'b1;
				if (wr_ok && bus.wstrb[0]) begin
					ctrl_q <= bus.wdata[1:0];
				end
			end else if (bus.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_go) begin
				rvalid_q <= 1'b1;
			end else if (bus.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// response payload, only sampled while valid is high
	always_ff @(posedge clk) begin
		if (wr_go) begin
			if (wr_ok)
				bresp_q <= axil_pkg::RESP_OKAY;
			else
				bresp_q <= axil_pkg::RESP_SLVERR;
		end
		if (rd_go) begin
			rdata_q <= rd_word;
			if (rd_ok)
				rresp_q <= axil_pkg::RESP_OKAY;
			else
				rresp_q <= axil_pkg::RESP_SLVERR;
		end
	end

	assign bus.bvalid = bvalid_q;
	assign bus.bresp = bresp_q;
	assign bus.rvalid = rvalid_q;
	assign bus.rdata = rdata_q;
	assign bus.rresp = rresp_q;

	assign god_mode = ctrl_q[0];
	assign rapid_fire = ctrl_q[1];

endmodule

//--- src/game_top.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module game_top (
	input logic clk,
	input logic resetN,
	input logic frame_tick,
	input logic shoot,
	input logic [7:0] random,
	input logic [`GAME_MAX_BIRDS-1:0] bird_alive,
	input logic hit_pulse,
	input logic powerup_hit,
	input logic out_of_time,
	input logic [3:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [3:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output logic [`GAME_MAX_SHOTS-1:0] deploy_shot,
	output logic [`GAME_MAX_TREES-1:0] deploy_tree,
	output logic [`GAME_MAX_BIRDS-1:0] deploy_bird,
	output logic [3:0] bird_life,
	output logic [2:0] tree_speed,
	output logic [1:0] bird_speed,
	output logic player_red,
	output logic player_active,
	output logic [1:0] lives,
	output logic [3:0] powerups,
	output logic add_time,
	output logic [7:0] time_to_add
);

	logic god_mode;
	logic rapid_fire;

	axil_if bus ();
	level_if lvl ();

	// host side of the bus, straight from the pins
	assign bus.awaddr = s_awaddr;
	assign bus.awvalid = s_awvalid;
	assign bus.wdata = s_wdata;
	assign bus.wstrb = s_wstrb;
	assign bus.wvalid = s_wvalid;
	assign bus.bready = s_bready;
	assign bus.araddr = s_araddr;
	assign bus.arvalid = s_arvalid;
	assign bus.rready = s_rready;
	assign s_awready = bus.awready;
	assign s_wready = bus.wready;
	assign s_bresp = bus.bresp;
	assign s_bvalid = bus.bvalid;
	assign s_arready = bus.arready;
	assign s_rdata = bus.rdata;
	assign s_rresp = bus.rresp;
	assign s_rvalid = bus.rvalid;

	game_regs u_regs (
		.clk(clk),
		.resetN(resetN),
		.bus(bus.slave),
		.lives(lives),
		.player_active(player_active),
		.level(lvl.level),
		.powerups(powerups),
		.god_mode(god_mode),
		.rapid_fire(rapid_fire)
	);

	level_fsm u_level (
		.clk(clk),
		.resetN(resetN),
		.lvl(lvl.fsm)
	);

	game_controller u_ctrl (
		.clk(clk),
		.resetN(resetN),
		.frame_tick(frame_tick),
		.shoot(shoot),
		.god_mode(god_mode),
		.rapid_fire(rapid_fire),
		.random(random),
		.bird_alive(bird_alive),
		.hit_pulse(hit_pulse),
		.powerup_hit(powerup_hit),
		.out_of_time(out_of_time),
		.lvl(lvl.ctrl),
		.deploy_shot(deploy_shot),
		.deploy_tree(deploy_tree),
		.deploy_bird(deploy_bird),
		.bird_life(bird_life),
		.tree_speed(tree_speed),
		.bird_speed(bird_speed),
		.player_red(player_red),
		.player_active(player_active),
		.lives(lives),
		.powerups(powerups),
		.add_time(add_time),
		.time_to_add(time_to_add)
	);

endmodule

//--- src/level_fsm.sv
`timescale 1ns/1ps

module level_fsm (
	input logic clk,
	input logic resetN,
	level_if.fsm lvl
);

	game_pkg::level_state_e state;
	game_pkg::level_cfg_t cfg_tbl;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= game_pkg::LEVEL_1;
		end else if (lvl.level_up && state != game_pkg::LEVEL_4) begin
			state <= game_pkg::level_state_e'(state + 2'd1); // level 4 repeats
		end
	end

	// per level settings, each level harder than the last
	always_comb begin
		case (state)
			game_pkg::LEVEL_1: cfg_tbl = '{
				tree_speed: 3'd1,
				bird_speed: 2'd1,
				bird_count: 2'd0,
				trees_to_add: 2'd1,
				bird_life: 4'd2
			};
			game_pkg::LEVEL_2: cfg_tbl = '{
				tree_speed: 3'd2,
				bird_speed: 2'd1,
				bird_count: 2'd1,
				trees_to_add: 2'd2,
				bird_life: 4'd4
			};
			game_pkg::LEVEL_3: cfg_tbl = '{
				tree_speed: 3'd3,
				bird_speed: 2'd2,
				bird_count: 2'd2,
				trees_to_add: 2'd2,
				bird_life: 4'd6
			};
			default: cfg_tbl = '{
				tree_speed: 3'd5,
				bird_speed: 2'd3,
				bird_count: 2'd3,
				trees_to_add: 2'd3,
				bird_life: 4'd8
			};
		endcase
	end

	assign lvl.cfg = cfg_tbl;
	assign lvl.level = state;

endmodule

//--- src/level_if.sv
`timescale 1ns/1ps

interface level_if;
	game_pkg::level_cfg_t cfg;
	game_pkg::level_state_e level;
	logic level_up; // one clock wide

	modport fsm (
		input level_up,
		output cfg,
		output level
	);

	modport ctrl (
		input cfg,
		input level,
		output level_up
	);
endinterface
